// ==== source/mldsa_dcmp_macros.svh ====
//**********************************************************************
// ML-DSA-87 decompose constants
// Modulus, GAMMA2 multiples and the widths of the decompose datapath
//**********************************************************************
`ifndef MLDSA_DCMP_MACROS_SVH
`define MLDSA_DCMP_MACROS_SVH

`define DCMP_Q               23'd8380417
`define DCMP_GAMMA2          19'd261888
`define DCMP_2GAMMA2         20'd523776
// Maps a negative centered r0 onto its mod-q value
`define DCMP_Q_MINUS_2GAMMA2 23'd7856641

`define DCMP_COEFF_W 23
`define DCMP_SLOT_W  24
`define DCMP_LANES   4
`define DCMP_ADDR_W  10
`define DCMP_WORDS   64

`endif

// ==== source/mldsa_dcmp_pkg.sv ====
//**********************************************************************
// ML-DSA-87 decompose types
// Vector typedefs and the mode and controller state enums
//**********************************************************************
`include "mldsa_dcmp_macros.svh"

package mldsa_dcmp_pkg;

    typedef logic [`DCMP_COEFF_W-1:0] coeff_t;
    typedef logic [18:0] mod2g_t;
    typedef logic [3:0] r1_t;
    typedef logic [`DCMP_ADDR_W-1:0] addr_t;
    typedef logic [`DCMP_LANES*`DCMP_SLOT_W-1:0] word_t;

    typedef enum logic {
        SIGN_OP   = 1'b0,
        VERIFY_OP = 1'b1
    } dcmp_mode_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } dcmp_state_t;

endpackage

// ==== source/decompose_ctrl.sv ====
//**********************************************************************
// Decompose controller
// Sequences 64 word reads, the delayed writes and the done pulse
//**********************************************************************
`timescale 1ns/100ps
`include "mldsa_dcmp_macros.svh"

module decompose_ctrl (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    output logic                            rd_en_o,
    output logic [$clog2(`DCMP_WORDS)-1:0]  rd_offset_o,
    output logic                            wr_en_o,
    output logic [$clog2(`DCMP_WORDS)-1:0]  wr_offset_o,
    output logic                            done_o
);

    localparam int OFS_W = $clog2(`DCMP_WORDS);
    localparam logic [OFS_W-1:0] OFS_LAST = OFS_W'(`DCMP_WORDS - 1);

    mldsa_dcmp_pkg::dcmp_state_t state_q, state_d;
    logic [OFS_W-1:0] rd_cnt_q;
    logic [2:0] en_pipe_q;
    logic [2:0][OFS_W-1:0] ofs_pipe_q;
    logic last_rd, last_wr;

    assign rd_en_o     = (state_q == mldsa_dcmp_pkg::RUN);
    assign rd_offset_o = rd_cnt_q;
    assign last_rd     = rd_en_o && (rd_cnt_q == OFS_LAST);

    // Write slot trails the read by data return, reduction and r0 stages
    assign wr_en_o     = en_pipe_q[2];
    assign wr_offset_o = ofs_pipe_q[2];
    assign last_wr     = wr_en_o && (wr_offset_o == OFS_LAST);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mldsa_dcmp_pkg::IDLE:  if (start_i) state_d = mldsa_dcmp_pkg::RUN;
            mldsa_dcmp_pkg::RUN:   if (last_rd) state_d = mldsa_dcmp_pkg::DRAIN;
            mldsa_dcmp_pkg::DRAIN: if (last_wr) state_d = mldsa_dcmp_pkg::IDLE;
            default:               state_d = mldsa_dcmp_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= mldsa_dcmp_pkg::IDLE;
            rd_cnt_q   <= '0;
            en_pipe_q  <= '0;
            ofs_pipe_q <= '0;
            done_o     <= 1'b0;
        end else begin
            state_q <= state_d;
            // Counter wraps back to zero after the last word
            if (rd_en_o) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            en_pipe_q  <= {en_pipe_q[1:0], rd_en_o};
            ofs_pipe_q <= {ofs_pipe_q[1:0], rd_offset_o};
            done_o     <= last_wr;
        end
    end

    a_no_wr_in_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state_q == mldsa_dcmp_pkg::IDLE) |-> !wr_en_o
    );

endmodule

// ==== source/decompose_r1_lut.sv ====
//**********************************************************************
// Decompose r1 lookup
// Threshold compare giving r1, the corner flag and r1 != 0
//**********************************************************************
`timescale 1ns/100ps
`include "mldsa_dcmp_macros.svh"

module decompose_r1_lut (
    input  mldsa_dcmp_pkg::coeff_t r_i,
    output mldsa_dcmp_pkg::r1_t    r1_o,
    output logic                   corner_o,
    output logic                   r1_nez_o
);

    mldsa_dcmp_pkg::coeff_t thr;
    mldsa_dcmp_pkg::r1_t count;

    // Count the odd multiples (2j-1)*GAMMA2 that lie below r
    always_comb begin
        thr   = mldsa_dcmp_pkg::coeff_t'(`DCMP_GAMMA2);
        count = '0;
        for (int j = 0; j < 15; j++) begin
            if (r_i > thr) begin
                count = count + 1'b1;
            end
            thr = thr + mldsa_dcmp_pkg::coeff_t'(`DCMP_2GAMMA2);
        end
    end

    // Above q-1-GAMMA2 the high part would be 16, which wraps to 0
    assign corner_o = (r_i > mldsa_dcmp_pkg::coeff_t'(`DCMP_Q - 23'd1 - `DCMP_GAMMA2));
    assign r1_o     = corner_o ? '0 : count;
    assign r1_nez_o = (r1_o != '0);

endmodule

// ==== source/decompose_mod_2gamma2.sv ====
//**********************************************************************
// Reduction modulo 2*GAMMA2
// Subtracts the largest fitting multiple and registers the residue
//**********************************************************************
`timescale 1ns/100ps
`include "mldsa_dcmp_macros.svh"

module decompose_mod_2gamma2 (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    en_i,
    input  mldsa_dcmp_pkg::coeff_t  r_i,
    output mldsa_dcmp_pkg::mod2g_t  res_o
);

    mldsa_dcmp_pkg::coeff_t mult, sub, diff;

    // Compare chain over k*2*GAMMA2 for k = 1..16, 16*2*GAMMA2 being q-1
    always_comb begin
        mult = '0;
        sub  = '0;
        for (int k = 1; k <= 16; k++) begin
            mult = mult + mldsa_dcmp_pkg::coeff_t'(`DCMP_2GAMMA2);
            if (r_i >= mult) begin
                sub = mult;
            end
        end
    end

    assign diff = r_i - sub;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (en_i) begin
            res_o <= mldsa_dcmp_pkg::mod2g_t'(diff);
        end
    end

endmodule

// ==== source/decompose_usehint.sv ====
//**********************************************************************
// UseHint correction
// Moves r1 up or down by one, modulo 16, when the hint bit is set
//**********************************************************************
`timescale 1ns/100ps
`include "mldsa_dcmp_macros.svh"

module decompose_usehint (
    input  logic                    clk,
    input  logic                    reset_n,
    input  mldsa_dcmp_pkg::coeff_t  r0_i,
    input  mldsa_dcmp_pkg::r1_t     r1_i,
    input  logic                    hint_i,
    output mldsa_dcmp_pkg::r1_t     r1_o
);

    logic r0_pos;

    // r0 arrives in mod-q form, so values above GAMMA2 stand for negatives
    assign r0_pos = (r0_i != '0) && (r0_i <= mldsa_dcmp_pkg::coeff_t'(`DCMP_GAMMA2));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r1_o <= '0;
        end else if (!hint_i) begin
            r1_o <= r1_i;
        end else if (r0_pos) begin
            r1_o <= r1_i + 1'b1;
        end else begin
            r1_o <= r1_i - 1'b1;
        end
    end

endmodule

// ==== source/decompose_w1_encode.sv ====
//**********************************************************************
// w1 packer
// Collects four 16-bit r1 groups into each 64-bit w1 word
//**********************************************************************
`timescale 1ns/100ps

module decompose_w1_encode (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        en_i,
    input  logic [15:0] r1_i,
    output logic [63:0] w1_o,
    output logic        w1_valid_o,
    output logic        w1_done_o
);

    logic [47:0] acc_q;
    logic [1:0]  grp_q;
    logic [3:0]  word_q;
    logic        last_grp;

    assign last_grp = en_i && (grp_q == 2'd3);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grp_q      <= '0;
            word_q     <= '0;
            w1_valid_o <= 1'b0;
            w1_done_o  <= 1'b0;
        end else begin
            if (en_i) begin
                grp_q <= grp_q + 1'b1;
            end
            if (last_grp) begin
                word_q <= word_q + 1'b1;
            end
            w1_valid_o <= last_grp;
            w1_done_o  <= last_grp && (word_q == 4'd15);
        end
    end

    // Shift right so group 0 ends up in the low bits of the word
    always_ff @(posedge clk) begin
        if (en_i) begin
            acc_q <= {r1_i, acc_q[47:16]};
        end
        if (last_grp) begin
            w1_o <= {r1_i, acc_q};
        end
    end

endmodule

// ==== source/decompose.sv ====
//**********************************************************************
// ML-DSA-87 decompose unit
// Splits each coefficient into r0 and r1, writes r0 and z, packs w1
//**********************************************************************
`timescale 1ns/100ps
`include "mldsa_dcmp_macros.svh"

module decompose (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start_i,
    input  mldsa_dcmp_pkg::dcmp_mode_t  mode_i,
    input  mldsa_dcmp_pkg::addr_t       src_base_i,
    input  mldsa_dcmp_pkg::addr_t       dest_base_i,
    input  mldsa_dcmp_pkg::addr_t       hint_base_i,
    input  mldsa_dcmp_pkg::word_t       mem_rd_data_i,
    input  mldsa_dcmp_pkg::word_t       hint_rd_data_i,
    output logic                        mem_rd_en_o,
    output mldsa_dcmp_pkg::addr_t       mem_rd_addr_o,
    output logic                        hint_rd_en_o,
    output mldsa_dcmp_pkg::addr_t       hint_rd_addr_o,
    output logic                        mem_wr_en_o,
    output mldsa_dcmp_pkg::addr_t       mem_wr_addr_o,
    output mldsa_dcmp_pkg::word_t       mem_wr_data_o,
    output logic                        z_wr_en_o,
    output logic [5:0]                  z_wr_addr_o,
    output logic [3:0]                  z_neq_z_o,
    output logic [63:0]                 w1_o,
    output logic                        w1_valid_o,
    output logic                        w1_done_o,
    output logic                        done_o
);

    logic verify, rd_en, wr_en, en_d1, en_d2, enc_en;
    logic [5:0] rd_ofs, wr_ofs;
    mldsa_dcmp_pkg::coeff_t coeff [`DCMP_LANES];
    mldsa_dcmp_pkg::coeff_t coeff_q [`DCMP_LANES];
    mldsa_dcmp_pkg::coeff_t r0 [`DCMP_LANES];
    mldsa_dcmp_pkg::coeff_t r0_q [`DCMP_LANES];
    mldsa_dcmp_pkg::mod2g_t res [`DCMP_LANES];
    mldsa_dcmp_pkg::r1_t r1 [`DCMP_LANES];
    mldsa_dcmp_pkg::r1_t r1_q [`DCMP_LANES];
    mldsa_dcmp_pkg::r1_t r1_hint [`DCMP_LANES];
    logic [`DCMP_LANES-1:0] corner, corner_q, nez, nez_d1, nez_d2, hint_q;
    logic [15:0] r1_pack;

    assign verify = (mode_i == mldsa_dcmp_pkg::VERIFY_OP);

    decompose_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .rd_en_o     (rd_en),
        .rd_offset_o (rd_ofs),
        .wr_en_o     (wr_en),
        .wr_offset_o (wr_ofs),
        .done_o      (done_o)
    );

    // en_d1 marks returned data
    // en_d2 marks a valid r1 register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_d1 <= 1'b0;
            en_d2 <= 1'b0;
        end else begin
            en_d1 <= rd_en;
            en_d2 <= en_d1;
        end
    end

    for (genvar i = 0; i < `DCMP_LANES; i++) begin : g_lane
        assign coeff[i] = mem_rd_data_i[i*`DCMP_SLOT_W +: `DCMP_COEFF_W];

        decompose_r1_lut u_lut (
            .r_i      (coeff[i]),
            .r1_o     (r1[i]),
            .corner_o (corner[i]),
            .r1_nez_o (nez[i])
        );

        decompose_mod_2gamma2 u_mod (
            .clk     (clk),
            .reset_n (reset_n),
            .en_i    (en_d1),
            .r_i     (coeff[i]),
            .res_o   (res[i])
        );

        // Centered r0 in mod-q form or the raw coefficient in the corner case
        always_comb begin
            if (corner_q[i]) begin
                r0[i] = coeff_q[i];
            end else if (res[i] <= `DCMP_GAMMA2) begin
                r0[i] = mldsa_dcmp_pkg::coeff_t'(res[i]);
            end else begin
                r0[i] = mldsa_dcmp_pkg::coeff_t'(res[i]) + `DCMP_Q_MINUS_2GAMMA2;
            end
        end

        always_ff @(posedge clk) begin
            coeff_q[i]  <= coeff[i];
            corner_q[i] <= corner[i];
            r1_q[i]     <= r1[i];
            nez_d1[i]   <= nez[i];
            nez_d2[i]   <= nez_d1[i];
            hint_q[i]   <= hint_rd_data_i[i*`DCMP_SLOT_W];
            r0_q[i]     <= r0[i];
        end

        decompose_usehint u_usehint (
            .clk     (clk),
            .reset_n (reset_n),
            .r0_i    (r0[i]),
            .r1_i    (r1_q[i]),
            .hint_i  (hint_q[i]),
            .r1_o    (r1_hint[i])
        );

        assign mem_wr_data_o[i*`DCMP_SLOT_W +: `DCMP_SLOT_W] = verify ? '0 : {1'b0, r0_q[i]};
        assign r1_pack[4*i +: 4] = verify ? r1_hint[i] : r1_q[i];

        // r1 from the compare path and r0 from the residue path rebuild the coefficient
        a_recombine: assert property (
            @(posedge clk) disable iff (!reset_n)
            en_d2 |-> (((24'(r1_q[i]) * 24'(`DCMP_2GAMMA2)) + 24'(r0[i])) % 24'(`DCMP_Q))
                      == 24'(coeff_q[i])
        );
    end

    // Verify mode waits one more cycle for the usehint register
    assign enc_en = verify ? wr_en : en_d2;

    decompose_w1_encode u_w1_enc (
        .clk        (clk),
        .reset_n    (reset_n),
        .en_i       (enc_en),
        .r1_i       (r1_pack),
        .w1_o       (w1_o),
        .w1_valid_o (w1_valid_o),
        .w1_done_o  (w1_done_o)
    );

    assign mem_rd_en_o    = rd_en;
    assign mem_rd_addr_o  = src_base_i + mldsa_dcmp_pkg::addr_t'(rd_ofs);
    assign hint_rd_en_o   = verify && rd_en;
    assign hint_rd_addr_o = verify ? hint_base_i + mldsa_dcmp_pkg::addr_t'(rd_ofs) : '0;
    assign mem_wr_en_o    = !verify && wr_en;
    assign mem_wr_addr_o  = verify ? '0 : dest_base_i + mldsa_dcmp_pkg::addr_t'(wr_ofs);
    assign z_wr_en_o      = !verify && wr_en;
    assign z_wr_addr_o    = verify ? '0 : wr_ofs;
    assign z_neq_z_o      = verify ? '0 : nez_d2;

endmodule

// ==== tests/decompose_tb.sv ====
//**********************************************************************
// Decompose unit testbench
// Memory models, reference decompose and a table of sign and verify runs
//**********************************************************************
`timescale 1ns/100ps

module decompose_tb;

    localparam int Q = 8380417;
    localparam int GAMMA2 = 261888;
    localparam int NTESTS = 6;
    localparam logic [1:0] FILL_RANDOM = 2'd0;
    localparam logic [1:0] FILL_BOUNDARY = 2'd1;
    localparam logic [1:0] FILL_ZERO = 2'd2;

    typedef struct packed {
        logic       verify;
        logic [9:0] src;
        logic [9:0] dest;
        logic [9:0] hint;
        logic [1:0] fill;
        logic       restart;
    } test_row_t;

    logic clk, reset_n, start_i;
    mldsa_dcmp_pkg::dcmp_mode_t mode_i;
    logic [9:0] src_base_i, dest_base_i, hint_base_i;
    logic [95:0] mem_rd_data_i = '0;
    logic [95:0] hint_rd_data_i = '0;
    logic mem_rd_en_o, hint_rd_en_o, mem_wr_en_o, z_wr_en_o;
    logic w1_valid_o, w1_done_o, done_o;
    logic [9:0] mem_rd_addr_o, hint_rd_addr_o, mem_wr_addr_o;
    logic [95:0] mem_wr_data_o;
    logic [5:0] z_wr_addr_o;
    logic [3:0] z_neq_z_o;
    logic [63:0] w1_o;

    logic [95:0] mem [1024];
    logic [95:0] hmem [1024];
    logic [3:0] zbuf [64];
    logic [63:0] w1_q [$];
    int unsigned coef [256];
    logic [95:0] src_words [64];
    logic [95:0] exp_r0w [64];
    logic [3:0] exp_z [64];
    logic [63:0] exp_w1 [16];
    test_row_t table_q [NTESTS];
    int errors, passed, rd_cnt, hrd_cnt, wr_cnt, z_cnt, done_cnt, w1_done_cnt, w1_done_pos;
    logic timed_out;

    decompose dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [95:0] got,
                                   input logic [95:0] exp);
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    // r1 counts the thresholds (2j-1)*GAMMA2 below r and r0 is r - r1*2*GAMMA2 mod q
    function automatic logic [26:0] decompose_model(input int unsigned r);
        int unsigned r1;
        int r0;
        if (r > Q - 1 - GAMMA2) return {4'd0, 23'(r)};
        r1 = (r + GAMMA2 - 1) / (2 * GAMMA2);
        r0 = int'(r) - int'(r1) * 2 * GAMMA2;
        if (r0 < 0) r0 = r0 + Q;
        return {4'(r1), 23'(r0)};
    endfunction

    function automatic logic [3:0] usehint_model(input logic [22:0] r0, input logic [3:0] r1,
                                                 input logic h);
        if (!h) return r1;
        if (r0 >= 1 && r0 <= GAMMA2) return r1 + 4'd1;
        return r1 - 4'd1;
    endfunction

    function automatic int unsigned boundary_value(input int n);
        case (n % 8)
            0: return 0;
            1: return GAMMA2;
            2: return GAMMA2 + 1;
            3: return Q - 2 - GAMMA2;
            4: return Q - 1 - GAMMA2;
            5: return Q - GAMMA2;
            6: return Q - 1;
            default: return 2 * GAMMA2;
        endcase
    endfunction

    // Memory models answer one cycle after the strobe and writes land in mem
    always @(posedge clk) begin
        if (mem_rd_en_o) begin
            if (mem_rd_addr_o !== src_base_i + 10'(rd_cnt))
                report_mismatch("mem_rd_addr_o", 96'(mem_rd_addr_o),
                                96'(src_base_i + 10'(rd_cnt)));
            mem_rd_data_i <= mem[mem_rd_addr_o];
            rd_cnt++;
        end
        if (hint_rd_en_o) begin
            if (hint_rd_addr_o !== hint_base_i + 10'(hrd_cnt))
                report_mismatch("hint_rd_addr_o", 96'(hint_rd_addr_o),
                                96'(hint_base_i + 10'(hrd_cnt)));
            hint_rd_data_i <= hmem[hint_rd_addr_o];
            hrd_cnt++;
        end
        if (mem_wr_en_o) begin
            if (mem_wr_addr_o !== dest_base_i + 10'(wr_cnt))
                report_mismatch("mem_wr_addr_o", 96'(mem_wr_addr_o),
                                96'(dest_base_i + 10'(wr_cnt)));
            mem[mem_wr_addr_o] = mem_wr_data_o;
            wr_cnt++;
        end
        if (z_wr_en_o) begin
            if (z_wr_addr_o !== 6'(z_cnt))
                report_mismatch("z_wr_addr_o", 96'(z_wr_addr_o), 96'(z_cnt));
            zbuf[z_wr_addr_o] = z_neq_z_o;
            z_cnt++;
        end
        if (w1_valid_o) w1_q.push_back(w1_o);
        if (w1_done_o) begin
            w1_done_cnt++;
            w1_done_pos = w1_q.size();
        end
        if (done_o) done_cnt++;
    end

    task automatic run_test(input int t);
        test_row_t row;
        int errs_before, cycles, n;
        logic [95:0] hw;
        logic [26:0] d;
        row = table_q[t];
        errs_before = errors;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = {4{14'h155, 10'(a)}};
            hmem[a] = {4{14'h0aa, 10'(a)}};
        end
        // Source polynomial, hints and the expected results per coefficient
        for (int k = 0; k < 64; k++) begin
            hw = {$urandom, $urandom, $urandom};
            hmem[row.hint + 10'(k)] = hw;
            for (int i = 0; i < 4; i++) begin
                n = 4 * k + i;
                case (row.fill)
                    FILL_RANDOM: coef[n] = $urandom % Q;
                    FILL_BOUNDARY: coef[n] = boundary_value(n);
                    default: coef[n] = 0;
                endcase
                d = decompose_model(coef[n]);
                src_words[k][24*i +: 24] = {1'b0, 23'(coef[n])};
                exp_r0w[k][24*i +: 24] = {1'b0, d[22:0]};
                exp_z[k][i] = (d[26:23] != 4'd0);
                exp_w1[n / 16][4 * (n % 16) +: 4] =
                    row.verify ? usehint_model(d[22:0], d[26:23], hw[24*i]) : d[26:23];
            end
            mem[row.src + 10'(k)] = src_words[k];
            zbuf[k] = 4'h0;
        end
        w1_q.delete();
        rd_cnt = 0;
        hrd_cnt = 0;
        wr_cnt = 0;
        z_cnt = 0;
        done_cnt = 0;
        w1_done_cnt = 0;
        w1_done_pos = 0;
        @(posedge clk);
        mode_i <= row.verify ? mldsa_dcmp_pkg::VERIFY_OP : mldsa_dcmp_pkg::SIGN_OP;
        src_base_i <= row.src;
        dest_base_i <= row.dest;
        hint_base_i <= row.hint;
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        // A second start in the middle of the run must be ignored
        if (row.restart) begin
            repeat (20) @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        cycles = 0;
        while (done_cnt == 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (done_cnt == 0) begin
            $display("timeout: done_o never rose in test %0d", t);
            errors++;
            timed_out = 1'b1;
            return;
        end
        repeat (5) @(posedge clk);
        if (rd_cnt != 64) report_mismatch("mem_rd_en_o count", 96'(rd_cnt), 96'd64);
        if (hrd_cnt != (row.verify ? 64 : 0))
            report_mismatch("hint_rd_en_o count", 96'(hrd_cnt), row.verify ? 96'd64 : 96'd0);
        if (done_cnt != 1) report_mismatch("done_o count", 96'(done_cnt), 96'd1);
        if (w1_q.size() != 16) report_mismatch("w1_valid_o count", 96'(w1_q.size()), 96'd16);
        if (w1_done_cnt != 1 || w1_done_pos != 16) begin
            $display("w1_done_o did not come once with the last w1 word in test %0d", t);
            errors++;
        end
        for (int w = 0; w < w1_q.size(); w++) begin
            if (w < 16 && w1_q[w] !== exp_w1[w])
                report_mismatch("w1_o", 96'(w1_q[w]), 96'(exp_w1[w]));
        end
        if (row.verify && (wr_cnt != 0 || z_cnt != 0)) begin
            $display("memory or z write seen in verify mode in test %0d", t);
            errors++;
        end
        if (!row.verify) begin
            if (wr_cnt != 64) report_mismatch("mem_wr_en_o count", 96'(wr_cnt), 96'd64);
            if (z_cnt != 64) report_mismatch("z_wr_en_o count", 96'(z_cnt), 96'd64);
            for (int k = 0; k < 64; k++) begin
                if (mem[row.dest + 10'(k)] !== exp_r0w[k])
                    report_mismatch("mem_wr_data_o", mem[row.dest + 10'(k)], exp_r0w[k]);
                if (zbuf[k] !== exp_z[k])
                    report_mismatch("z_neq_z_o", 96'(zbuf[k]), 96'(exp_z[k]));
            end
        end
        for (int k = 0; k < 64; k++) begin
            if (mem[row.src + 10'(k)] !== src_words[k])
                report_mismatch("source word", mem[row.src + 10'(k)], src_words[k]);
        end
        if (errors == errs_before) begin
            $display("test %0d ok", t);
            passed++;
        end else begin
            $display("test %0d FAIL with %0d errors", t, errors - errs_before);
        end
    endtask

    initial begin
        void'($urandom(93));
        reset_n = 1'b0;
        start_i = 1'b0;
        mode_i = mldsa_dcmp_pkg::SIGN_OP;
        src_base_i = '0;
        dest_base_i = '0;
        hint_base_i = '0;
        errors = 0;
        passed = 0;
        timed_out = 1'b0;
        // verify, src, dest, hint, fill, restart
        table_q[0] = '{1'b0, 10'h000, 10'h100, 10'h000, FILL_RANDOM, 1'b0};
        table_q[1] = '{1'b0, 10'h040, 10'h080, 10'h000, FILL_BOUNDARY, 1'b0};
        table_q[2] = '{1'b0, 10'h200, 10'h300, 10'h000, FILL_ZERO, 1'b0};
        table_q[3] = '{1'b1, 10'h000, 10'h000, 10'h3c0, FILL_RANDOM, 1'b1};
        table_q[4] = '{1'b1, 10'h100, 10'h000, 10'h200, FILL_BOUNDARY, 1'b0};
        table_q[5] = '{1'b0, 10'h380, 10'h000, 10'h000, FILL_RANDOM, 1'b1};
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        if ({mem_rd_en_o, hint_rd_en_o, mem_wr_en_o, z_wr_en_o, w1_valid_o, w1_done_o,
             done_o} !== 7'b0) begin
            $display("a strobe, valid or done output is high after reset");
            errors++;
        end else begin
            $display("reset check ok");
            passed++;
        end
        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            run_test(t);
        end
        $display("summary: %0d passed, %0d errors, %0d total", passed, errors, NTESTS + 1);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/mldsa_dcmp_pkg.sv
source/decompose_ctrl.sv
source/decompose_r1_lut.sv
source/decompose_mod_2gamma2.sv
source/decompose_usehint.sv
source/decompose_w1_encode.sv
source/decompose.sv
tests/decompose_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := decompose_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
